/* hdl/dbg_pkg.sv */
package dbg_pkg;

	// ########################################
	// Sizes and timing
	// ########################################

	localparam int WORD_W = 32;
	localparam int ADDR_W = 5;

	// Simulation baud divisor
	localparam int CLKS_PER_BIT = 8;

	// Words per dump
	localparam int NUM_REGS = 32;
	localparam int NUM_MEM  = 16;

	// ########################################
	// Host protocol
	// ########################################

	localparam logic [7:0] CMD_REGS = 8'h01;
	localparam logic [7:0] CMD_MEM  = 8'h02;
	localparam logic [7:0] CMD_PC   = 8'h03;
	localparam logic [7:0] ERR_BYTE = 8'hee;

	// Read space on the core side
	typedef enum logic [1:0] {
		SEL_REG,
		SEL_MEM,
		SEL_PC
	} tgt_sel_t;

	typedef struct packed {
		tgt_sel_t          sel;
		logic [ADDR_W-1:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} tx_byte_t;

endpackage

/* hdl/uart_rx.sv */
module uart_rx (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rx,
	output logic       cmd_valid,
	output logic [7:0] cmd_byte
);
	import dbg_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t                       state;
	logic [2:0]                      sync;
	logic [$clog2(CLKS_PER_BIT)-1:0] tick;
	logic [2:0]                      bit_idx;
	logic [7:0]                      shreg;
	logic                            rx_s;
	logic                            start_edge;

	// Two flops for metastability, the third keeps the previous value
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync <= 3'b111;
		end else begin
			sync <= {sync[1:0], rx};
		end
	end

	assign rx_s       = sync[1];
	assign start_edge = sync[2] & ~sync[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= RX_IDLE;
			tick      <= '0;
			bit_idx   <= '0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					tick    <= '0;
					bit_idx <= '0;
					if (start_edge) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// Glitch check at the middle of the start bit
					if (tick == CLKS_PER_BIT / 2 - 1) begin
						tick  <= '0;
						state <= rx_s ? RX_IDLE : RX_DATA;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				RX_DATA: begin
					if (tick == CLKS_PER_BIT - 1) begin
						tick    <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						tick <= tick + 1'b1;
					end
				end
				default: begin
					// Bad stop bit drops the frame silently
					if (tick == CLKS_PER_BIT - 1) begin
						cmd_valid <= rx_s;
						state     <= RX_IDLE;
					end else begin
						tick <= tick + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && tick == CLKS_PER_BIT - 1) begin
			shreg <= {rx_s, shreg[7:1]};
		end
	end

	assign cmd_byte = shreg;

endmodule

/* hdl/uart_tx.sv */
module uart_tx (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              tx_req,
	input  dbg_pkg::tx_byte_t tx_byte,
	output logic              tx_ack,
	output logic              tx
);
	import dbg_pkg::*;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_SEND,
		TX_ACK
	} tx_state_t;

	tx_state_t                       state;
	logic [$clog2(CLKS_PER_BIT)-1:0] tick;
	logic [3:0]                      bit_idx;
	// Data bits with the stop bit behind them
	logic [8:0]                      shreg;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= TX_IDLE;
			tick    <= '0;
			bit_idx <= '0;
			tx_ack  <= 1'b0;
			tx      <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_req) begin
						// Start bit
						tx      <= 1'b0;
						tick    <= '0;
						bit_idx <= '0;
						state   <= TX_SEND;
					end
				end
				TX_SEND: begin
					if (tick == CLKS_PER_BIT - 1) begin
						tick <= '0;
						if (bit_idx == 4'd9) begin
							tx_ack <= 1'b1;
							state  <= TX_ACK;
						end else begin
							tx      <= shreg[0];
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						tick <= tick + 1'b1;
					end
				end
				default: begin
					// Line stays at the stop level until the next byte
					if (!tx_req) begin
						tx_ack <= 1'b0;
						state  <= TX_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == TX_IDLE && tx_req) begin
			shreg <= {1'b1, tx_byte.data};
		end else if (state == TX_SEND && tick == CLKS_PER_BIT - 1) begin
			shreg <= {1'b1, shreg[8:1]};
		end
	end

endmodule

/* hdl/recolector.sv */
module recolector (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       rd_req_valid,
	input  dbg_pkg::rd_req_t           rd_req,
	output logic                       rd_ack,
	output logic [dbg_pkg::WORD_W-1:0] rd_word,
	output dbg_pkg::rd_req_t           tgt_rd,
	input  logic [dbg_pkg::WORD_W-1:0] tgt_data
);

	typedef enum logic [1:0] {
		RC_IDLE,
		RC_WAIT,
		RC_ACK
	} rc_state_t;

	rc_state_t state;

	// Core answers one clock after tgt_rd changes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= RC_IDLE;
			rd_ack <= 1'b0;
			tgt_rd <= '0;
		end else begin
			case (state)
				RC_IDLE: begin
					if (rd_req_valid) begin
						tgt_rd <= rd_req;
						state  <= RC_WAIT;
					end
				end
				RC_WAIT: begin
					state <= RC_ACK;
				end
				default: begin
					// First clock here captures, then hold until req drops
					if (!rd_ack) begin
						rd_ack <= 1'b1;
					end else if (!rd_req_valid) begin
						rd_ack <= 1'b0;
						state  <= RC_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RC_ACK && !rd_ack) begin
			rd_word <= tgt_data;
		end
	end

endmodule

/* hdl/debug_ctrl.sv */
module debug_ctrl (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       cmd_valid,
	input  logic [7:0]                 cmd_byte,
	output logic                       rd_req_valid,
	output dbg_pkg::rd_req_t           rd_req,
	input  logic                       rd_ack,
	input  logic [dbg_pkg::WORD_W-1:0] rd_word,
	output logic                       tx_req,
	output dbg_pkg::tx_byte_t          tx_byte,
	input  logic                       tx_ack
);
	import dbg_pkg::*;

	typedef enum logic [2:0] {
		CT_IDLE,
		CT_FETCH,
		CT_FETCH_END,
		CT_SEND,
		CT_SEND_END
	} ct_state_t;

	ct_state_t         state;
	logic [WORD_W-1:0] word_q;
	logic [1:0]        byte_idx;
	logic [ADDR_W:0]   words_left;
	logic [1:0]        next_idx;

	assign next_idx = byte_idx + 2'd1;

	// ########################################
	// Reply sequencer
	// ########################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= CT_IDLE;
			rd_req_valid <= 1'b0;
			rd_req       <= '0;
			tx_req       <= 1'b0;
			tx_byte      <= '0;
			byte_idx     <= '0;
			words_left   <= '0;
		end else begin
			case (state)
				CT_IDLE: begin
					if (cmd_valid) begin
						rd_req.addr <= '0;
						case (cmd_byte)
							CMD_REGS: begin
								rd_req.sel   <= SEL_REG;
								words_left   <= (ADDR_W + 1)'(NUM_REGS);
								rd_req_valid <= 1'b1;
								state        <= CT_FETCH;
							end
							CMD_MEM: begin
								rd_req.sel   <= SEL_MEM;
								words_left   <= (ADDR_W + 1)'(NUM_MEM);
								rd_req_valid <= 1'b1;
								state        <= CT_FETCH;
							end
							CMD_PC: begin
								rd_req.sel   <= SEL_PC;
								words_left   <= (ADDR_W + 1)'(1);
								rd_req_valid <= 1'b1;
								state        <= CT_FETCH;
							end
							default: begin
								// Single byte error reply
								tx_byte.data <= ERR_BYTE;
								tx_byte.last <= 1'b1;
								tx_req       <= 1'b1;
								state        <= CT_SEND;
							end
						endcase
					end
				end
				CT_FETCH: begin
					if (rd_ack) begin
						rd_req_valid <= 1'b0;
						state        <= CT_FETCH_END;
					end
				end
				CT_FETCH_END: begin
					if (!rd_ack) begin
						byte_idx     <= '0;
						tx_byte.data <= word_q[7:0];
						tx_byte.last <= 1'b0;
						tx_req       <= 1'b1;
						state        <= CT_SEND;
					end
				end
				CT_SEND: begin
					if (tx_ack) begin
						tx_req <= 1'b0;
						state  <= CT_SEND_END;
					end
				end
				default: begin
					if (!tx_ack) begin
						if (tx_byte.last) begin
							state <= CT_IDLE;
						end else if (byte_idx == 2'd3) begin
							// Word done, go get the next one
							words_left   <= words_left - 1'b1;
							rd_req.addr  <= rd_req.addr + 1'b1;
							rd_req_valid <= 1'b1;
							state        <= CT_FETCH;
						end else begin
							byte_idx     <= next_idx;
							tx_byte.data <= word_q[next_idx * 8 +: 8];
							tx_byte.last <= (next_idx == 2'd3) && (words_left == 1);
							tx_req       <= 1'b1;
							state        <= CT_SEND;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == CT_FETCH && rd_ack) begin
			word_q <= rd_word;
		end
	end

endmodule

/* hdl/debug_link.sv */
module debug_link (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       rx,
	output logic                       tx,
	output dbg_pkg::rd_req_t           tgt_rd,
	input  logic [dbg_pkg::WORD_W-1:0] tgt_data
);
	import dbg_pkg::*;

	logic              cmd_valid;
	logic [7:0]        cmd_byte;
	logic              rd_req_valid;
	rd_req_t           rd_req;
	logic              rd_ack;
	logic [WORD_W-1:0] rd_word;
	logic              tx_req;
	tx_byte_t          tx_byte;
	logic              tx_ack;

	// ########################################
	// Host side
	// ########################################

	uart_rx u_uart_rx (
		.clk       (clk),
		.arst_n    (arst_n),
		.rx        (rx),
		.cmd_valid (cmd_valid),
		.cmd_byte  (cmd_byte)
	);

	uart_tx u_uart_tx (
		.clk     (clk),
		.arst_n  (arst_n),
		.tx_req  (tx_req),
		.tx_byte (tx_byte),
		.tx_ack  (tx_ack),
		.tx      (tx)
	);

	// ########################################
	// Core side
	// ########################################

	recolector u_recolector (
		.clk          (clk),
		.arst_n       (arst_n),
		.rd_req_valid (rd_req_valid),
		.rd_req       (rd_req),
		.rd_ack       (rd_ack),
		.rd_word      (rd_word),
		.tgt_rd       (tgt_rd),
		.tgt_data     (tgt_data)
	);

	debug_ctrl u_debug_ctrl (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd_valid    (cmd_valid),
		.cmd_byte     (cmd_byte),
		.rd_req_valid (rd_req_valid),
		.rd_req       (rd_req),
		.rd_ack       (rd_ack),
		.rd_word      (rd_word),
		.tx_req       (tx_req),
		.tx_byte      (tx_byte),
		.tx_ack       (tx_ack)
	);

endmodule

/* testbench/debug_link_chk.sv */
module debug_link_chk (
	input logic              clk,
	input logic              arst_n,
	input logic              tx,
	input logic              rd_req_valid,
	input dbg_pkg::rd_req_t  rd_req,
	input logic              rd_ack,
	input logic              tx_req,
	input dbg_pkg::tx_byte_t tx_byte,
	input logic              tx_ack
);

	int violations = 0;

	// Acks only rise while a request is pending
	a_rd_ack: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(rd_ack) |-> rd_req_valid)
		else begin
			$error("rd_ack rose while rd_req_valid was low");
			violations++;
		end

	a_tx_ack: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(tx_ack) |-> tx_req)
		else begin
			$error("tx_ack rose while tx_req was low");
			violations++;
		end

	a_rd_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(rd_req_valid && $past(rd_req_valid)) |-> $stable(rd_req))
		else begin
			$error("rd_req changed during a fetch");
			violations++;
		end

	a_tx_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(tx_req && $past(tx_req)) |-> $stable(tx_byte))
		else begin
			$error("tx_byte changed during a send");
			violations++;
		end

	// Both handshake lines low means the transmitter is idle
	a_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
		(!tx_req && !tx_ack) |-> tx)
		else begin
			$error("tx low while the transmitter is idle");
			violations++;
		end

endmodule

/* testbench/tb_debug_link.sv */
module tb_debug_link;
	import dbg_pkg::*;

	localparam int NUM_TESTS  = 5;
	localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;

	logic              clk = 1'b0;
	logic              arst_n;
	logic              rx;
	logic              tx;
	rd_req_t           tgt_rd;
	logic [WORD_W-1:0] tgt_data = '0;

	// Core model contents
	logic [WORD_W-1:0] regs [NUM_REGS];
	logic [WORD_W-1:0] mem [NUM_MEM];
	logic [WORD_W-1:0] pc_value;
	logic [31:0]       rng;

	// Command table
	string             test_name [NUM_TESTS] = '{"regs", "mem", "pc", "bad_00", "bad_7f"};
	logic [7:0]        test_cmd [NUM_TESTS] = '{CMD_REGS, CMD_MEM, CMD_PC, 8'h00, 8'h7f};
	int                test_len [NUM_TESTS] = '{NUM_REGS * 4, NUM_MEM * 4, 4, 1, 1};

	int                cycles = 0;
	int                cycle_limit;
	int                errors = 0;
	int                n_pass = 0;
	int                n_fail = 0;

	debug_link dut0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.rx       (rx),
		.tx       (tx),
		.tgt_rd   (tgt_rd),
		.tgt_data (tgt_data)
	);

	bind debug_link debug_link_chk chk0 (.*);

	always #20 clk = ~clk;

	// ########################################
	// Core model and watchdog
	// ########################################

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [WORD_W-1:0] core_word(input rd_req_t rd);
		case (rd.sel)
			SEL_REG: return regs[rd.addr];
			SEL_MEM: return mem[rd.addr[3:0]];
			SEL_PC:  return pc_value;
			default: return '0;
		endcase
	endfunction

	// Word is ready well before the collector captures it
	always @(negedge clk) begin
		tgt_data <= core_word(tgt_rd);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Run stopped after %0d cycles, the DUT stopped answering", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	// ########################################
	// Serial driver, monitor and checks
	// ########################################

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic send_frame(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(negedge clk);
		end
	endtask

	// Waits up to wait_clks for a start bit and samples each bit mid-way
	task automatic receive_byte(input string name, input int wait_clks,
		output logic [7:0] data, output bit got);
		int waited;
		waited = 0;
		got = 1'b0;
		data = '0;
		@(negedge clk);
		while (tx !== 1'b0 && waited < wait_clks) begin
			@(negedge clk);
			waited++;
		end
		if (tx === 1'b0) begin
			got = 1'b1;
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			check_equal({name, " start bit"}, 32'd0, {31'd0, tx});
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				data[i] = tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			check_equal({name, " stop bit"}, 32'd1, {31'd0, tx});
		end
	endtask

	function automatic logic [7:0] expected_byte(input logic [7:0] cmd, input int idx);
		logic [31:0] w;
		case (cmd)
			CMD_REGS: w = regs[idx / 4];
			CMD_MEM:  w = mem[idx / 4];
			CMD_PC:   w = pc_value;
			default:  return ERR_BYTE;
		endcase
		return w[(idx % 4) * 8 +: 8];
	endfunction

	task automatic receive_reply(input int t);
		logic [7:0] data;
		bit         got;
		for (int i = 0; i < test_len[t]; i++) begin
			receive_byte($sformatf("%s byte %0d", test_name[t], i), 4 * FRAME_CLKS, data, got);
			if (!got) begin
				$display("%s: reply byte %0d never arrived", test_name[t], i);
				errors++;
				break;
			end
			check_equal($sformatf("%s byte %0d", test_name[t], i),
				{24'd0, expected_byte(test_cmd[t], i)}, {24'd0, data});
		end
		// Single byte replies must be followed by silence
		if (test_len[t] == 1) begin
			receive_byte({test_name[t], " extra"}, 2 * FRAME_CLKS, data, got);
			if (got) begin
				$display("%s: unexpected byte %h after the reply", test_name[t], data);
				errors++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: ok", name);
			n_pass++;
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
			n_fail++;
		end
	endtask

	// ########################################
	// Main sequence
	// ########################################

	initial begin
		logic [7:0] data;
		bit         got;
		int         errors_before;
		arst_n = 1'b0;
		rx = 1'b1;
		rng = 32'hd9e7318b;
		for (int i = 0; i < NUM_REGS; i++) begin
			rng = lcg_next(rng);
			regs[i] = rng;
		end
		for (int i = 0; i < NUM_MEM; i++) begin
			rng = lcg_next(rng);
			mem[i] = rng;
		end
		pc_value = 32'h0000_0a4c;
		cycle_limit = 2000;
		for (int t = 0; t < NUM_TESTS; t++) begin
			cycle_limit += (test_len[t] + 1) * FRAME_CLKS;
		end
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		// Quiet line before any command
		errors_before = errors;
		check_equal("idle line", 32'd1, {31'd0, tx});
		receive_byte("idle", FRAME_CLKS, data, got);
		if (got) begin
			$display("idle: byte %h received before any command", data);
			errors++;
		end
		report_test("idle", errors_before);

		for (int t = 0; t < NUM_TESTS; t++) begin
			errors_before = errors;
			fork
				send_frame(test_cmd[t]);
				receive_reply(t);
			join
			report_test(test_name[t], errors_before);
		end

		if (dut0.chk0.violations != 0) begin
			$display("bound assertions failed %0d times", dut0.chk0.violations);
			n_fail++;
		end
		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* src.f */
hdl/dbg_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/recolector.sv
hdl/debug_ctrl.sv
hdl/debug_link.sv
testbench/debug_link_chk.sv
testbench/tb_debug_link.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_debug_link
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
